/* rtl/memedf_pkg.sv */
package memedf_pkg;

    ////////////////////
    // Widths
    ////////////////////
    localparam int addr_w    = 32;
    localparam int data_w    = 32;
    localparam int timer_w   = 16;
    localparam int prio_w    = 4;
    localparam int max_cores = 8;

    // Enough bits to name any core up to max_cores
    localparam int core_id_w = $clog2(max_cores);

    typedef logic [core_id_w-1:0] core_id_t;

    // One memory request as it moves through the scheduler
    typedef struct packed {
        core_id_t            core;
        logic [addr_w-1:0]   addr;
        logic [data_w-1:0]   data;
    } mem_packet_t;

    ////////////////////
    // Configuration
    ////////////////////
    typedef enum logic {
        mode_fp  = 1'b0,
        mode_edf = 1'b1
    } sched_mode_t;

    typedef enum logic [1:0] {
        field_period   = 2'd0,
        field_deadline = 2'd1,
        field_priority = 2'd2,
        field_mode     = 2'd3
    } cfg_field_t;

    // Register write strobe, applied on the clock edge
    typedef struct packed {
        logic                wr;
        cfg_field_t          field;
        core_id_t            core;
        logic [timer_w-1:0]  value;
    } cfg_write_t;

endpackage

/* rtl/config_regs.sv */
`timescale 1ns/100ps

module config_regs
    import memedf_pkg::*;
#(
    parameter int num_cores = 4
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  cfg_write_t                           cfg_wr,
    input  core_id_t                             cfg_rd_core,
    input  cfg_field_t                           cfg_rd_field,
    output logic [timer_w-1:0]                   cfg_rd_data,
    output logic [num_cores-1:0][timer_w-1:0]    periods,
    output logic [num_cores-1:0][timer_w-1:0]    deadlines,
    output logic [num_cores-1:0][prio_w-1:0]     priorities,
    output sched_mode_t                          mode,
    output logic [num_cores-1:0]                 period_reload
);

    ////////////////////
    // Register writes
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            periods       <= '0;
            deadlines     <= '0;
            priorities    <= '0;
            mode          <= mode_fp;
            period_reload <= '0;
        end else begin
            period_reload <= '0;
            if (cfg_wr.wr) begin
                if (cfg_wr.field == field_mode) begin
                    mode <= sched_mode_t'(cfg_wr.value[0]);
                end
                for (int c = 0; c < num_cores; c++) begin
                    if (cfg_wr.core == core_id_t'(c)) begin
                        case (cfg_wr.field)
                            field_period: begin
                                periods[c]       <= cfg_wr.value;
                                // Timers restart once the new period is visible
                                period_reload[c] <= 1'b1;
                            end
                            field_deadline: deadlines[c]  <= cfg_wr.value;
                            field_priority: priorities[c] <= cfg_wr.value[prio_w-1:0];
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    // Readback mux
    always_comb begin
        cfg_rd_data = '0;
        if (cfg_rd_field == field_mode) begin
            cfg_rd_data = timer_w'(mode);
        end else begin
            for (int c = 0; c < num_cores; c++) begin
                if (cfg_rd_core == core_id_t'(c)) begin
                    case (cfg_rd_field)
                        field_period:   cfg_rd_data = periods[c];
                        field_deadline: cfg_rd_data = deadlines[c];
                        default:        cfg_rd_data = timer_w'(priorities[c]);
                    endcase
                end
            end
        end
    end

    // Software must only address cores that exist
    a_wr_core_range: assert property (@(posedge clock) disable iff (rst)
        cfg_wr.wr |-> (int'(cfg_wr.core) < num_cores));

endmodule

/* rtl/core_queue_bank.sv */
`timescale 1ns/100ps

module core_queue_bank
    import memedf_pkg::*;
#(
    parameter int num_cores   = 4,
    parameter int queue_depth = 4
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          req_valid,
    input  mem_packet_t                   req_packet,
    input  logic                          pop,
    input  core_id_t                      pop_core,
    output logic                          stall,
    output logic [num_cores-1:0]          nonempty,
    output mem_packet_t [num_cores-1:0]   head
);

    localparam int ptr_w = $clog2(queue_depth);
    localparam int cnt_w = ptr_w + 1;

    mem_packet_t        mem [num_cores][queue_depth];
    logic [ptr_w-1:0]   rd_ptr [num_cores];
    logic [ptr_w-1:0]   wr_ptr [num_cores];
    logic [cnt_w-1:0]   count [num_cores];

    logic [num_cores-1:0] full;
    logic [num_cores-1:0] push_en;
    logic [num_cores-1:0] pop_en;

    ////////////////////
    // Intake routing
    ////////////////////

    // Stall follows the queue that the incoming request targets
    always_comb begin
        stall = 1'b0;
        for (int c = 0; c < num_cores; c++) begin
            if (req_packet.core == core_id_t'(c)) begin
                stall = full[c];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < num_cores; c++) begin
            push_en[c] = req_valid && !stall && (req_packet.core == core_id_t'(c));
            pop_en[c]  = pop && (pop_core == core_id_t'(c));
        end
    end

    ////////////////////
    // Per-core FIFOs
    ////////////////////
    always_ff @(posedge clock) begin
        for (int c = 0; c < num_cores; c++) begin
            if (push_en[c]) begin
                mem[c][wr_ptr[c]] <= req_packet;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int c = 0; c < num_cores; c++) begin
                rd_ptr[c] <= '0;
                wr_ptr[c] <= '0;
                count[c]  <= '0;
            end
        end else begin
            for (int c = 0; c < num_cores; c++) begin
                // Pointers wrap on their own since depth is a power of two
                if (push_en[c]) begin
                    wr_ptr[c] <= wr_ptr[c] + 1'b1;
                end
                if (pop_en[c]) begin
                    rd_ptr[c] <= rd_ptr[c] + 1'b1;
                end
                case ({push_en[c], pop_en[c]})
                    2'b10:   count[c] <= count[c] + 1'b1;
                    2'b01:   count[c] <= count[c] - 1'b1;
                    default: ;
                endcase
            end
        end
    end

    for (genvar c = 0; c < num_cores; c++) begin : g_status
        assign full[c]     = (count[c] == cnt_w'(queue_depth));
        assign nonempty[c] = (count[c] != '0);
        assign head[c]     = mem[c][rd_ptr[c]];

        // Occupancy stays in range and agrees with the pointer distance
        a_no_overflow: assert property (@(posedge clock) disable iff (rst)
            (count[c] <= cnt_w'(queue_depth)) &&
            (count[c][ptr_w-1:0] == ptr_w'(wr_ptr[c] - rd_ptr[c])));
        // Issue stage must only pop what the selector saw as waiting
        a_no_underflow: assert property (@(posedge clock) disable iff (rst)
            !(pop_en[c] && !nonempty[c]));
    end

endmodule

/* rtl/deadline_timers.sv */
`timescale 1ns/100ps

module deadline_timers
    import memedf_pkg::*;
#(
    parameter int num_cores = 4
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  logic [num_cores-1:0][timer_w-1:0]    periods,
    input  logic [num_cores-1:0][timer_w-1:0]    deadlines,
    input  logic [num_cores-1:0]                 period_reload,
    output logic [num_cores-1:0][timer_w-1:0]    remaining
);

    logic [timer_w-1:0] period_cnt [num_cores];

    ////////////////////
    // Countdowns
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            remaining <= '0;
            for (int c = 0; c < num_cores; c++) begin
                period_cnt[c] <= '0;
            end
        end else begin
            for (int c = 0; c < num_cores; c++) begin
                if (period_reload[c] || (period_cnt[c] == '0)) begin
                    // New period starts, deadline window opens again
                    period_cnt[c] <= periods[c];
                    remaining[c]  <= deadlines[c];
                end else begin
                    period_cnt[c] <= period_cnt[c] - 1'b1;
                    // Saturate at zero once the deadline has passed
                    if (remaining[c] != '0) begin
                        remaining[c] <= remaining[c] - 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* rtl/queue_selector.sv */
`timescale 1ns/100ps

module queue_selector
    import memedf_pkg::*;
#(
    parameter int num_cores = 4
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  logic [num_cores-1:0]                 nonempty,
    input  logic [num_cores-1:0][prio_w-1:0]     priorities,
    input  logic [num_cores-1:0][timer_w-1:0]    remaining,
    input  sched_mode_t                          mode,
    output logic                                 grant_valid,
    output core_id_t                             grant_core
);

    logic [timer_w-1:0] keys [num_cores];
    logic [timer_w-1:0] best_key;
    logic               grant_ok;
    logic               beaten;

    // Sort key per core, smaller wins in both policies
    always_comb begin
        for (int c = 0; c < num_cores; c++) begin
            if (mode == mode_edf) begin
                keys[c] = remaining[c];
            end else begin
                keys[c] = timer_w'(priorities[c]);
            end
        end
    end

    ////////////////////
    // Linear scan
    ////////////////////
    always_comb begin
        grant_valid = 1'b0;
        grant_core  = '0;
        best_key    = '0;
        for (int c = 0; c < num_cores; c++) begin
            // Strict compare keeps the lower index on a tie
            if (nonempty[c] && (!grant_valid || keys[c] < best_key)) begin
                grant_valid = 1'b1;
                grant_core  = core_id_t'(c);
                best_key    = keys[c];
            end
        end
    end

    // Granted core waits, and no other waiting core outranks it
    always_comb begin
        grant_ok = 1'b0;
        beaten   = 1'b0;
        for (int g = 0; g < num_cores; g++) begin
            if (grant_core == core_id_t'(g)) begin
                grant_ok = nonempty[g];
                for (int c = 0; c < num_cores; c++) begin
                    if (nonempty[c] && ((keys[c] < keys[g]) ||
                                        ((keys[c] == keys[g]) && (c < g)))) begin
                        beaten = 1'b1;
                    end
                end
            end
        end
    end

    a_grant_best: assert property (@(posedge clock) disable iff (rst)
        grant_valid ? (grant_ok && !beaten) : (nonempty == '0));

endmodule

/* rtl/packet_issuer.sv */
`timescale 1ns/100ps

module packet_issuer
    import memedf_pkg::*;
#(
    parameter int num_cores = 4
) (
    input  logic                          clock,
    input  logic                          rst,
    input  logic                          grant_valid,
    input  core_id_t                      grant_core,
    input  mem_packet_t [num_cores-1:0]   head,
    input  logic                          out_consumed,
    output logic                          pop,
    output core_id_t                      pop_core,
    output logic                          out_valid,
    output mem_packet_t                   out_packet
);

    mem_packet_t granted;

    always_comb begin
        granted = head[0];
        for (int c = 0; c < num_cores; c++) begin
            if (grant_core == core_id_t'(c)) begin
                granted = head[c];
            end
        end
    end

    // Free slot, or the current packet leaves this cycle
    assign pop      = grant_valid && (!out_valid || out_consumed);
    assign pop_core = grant_core;

    ////////////////////
    // Output slot
    ////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (pop) begin
            out_valid <= 1'b1;
        end else if (out_consumed) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            out_packet <= granted;
        end
    end

    // Queues hold only their own core's packets
    a_pop_core_match: assert property (@(posedge clock) disable iff (rst)
        pop |=> (out_packet.core == $past(pop_core)));

endmodule

/* rtl/memedf_top.sv */
`timescale 1ns/100ps

module memedf_top
    import memedf_pkg::*;
#(
    parameter int num_cores   = 4,
    parameter int queue_depth = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                req_valid,
    input  mem_packet_t         req_packet,
    output logic                stall,
    input  cfg_write_t          cfg_wr,
    input  core_id_t            cfg_rd_core,
    input  cfg_field_t          cfg_rd_field,
    output logic [timer_w-1:0]  cfg_rd_data,
    output logic                out_valid,
    output mem_packet_t         out_packet,
    input  logic                out_consumed
);

    ////////////////////
    // Internal wiring
    ////////////////////
    logic [num_cores-1:0][timer_w-1:0]   periods;
    logic [num_cores-1:0][timer_w-1:0]   deadlines;
    logic [num_cores-1:0][prio_w-1:0]    priorities;
    logic [num_cores-1:0][timer_w-1:0]   remaining;
    logic [num_cores-1:0]                period_reload;
    logic [num_cores-1:0]                nonempty;
    mem_packet_t [num_cores-1:0]         head;
    sched_mode_t                         mode;
    logic                                grant_valid;
    core_id_t                            grant_core;
    logic                                pop;
    core_id_t                            pop_core;

    config_regs #(
        .num_cores(num_cores)
    ) config_regs_i (
        .clock(clock),
        .rst(rst),
        .cfg_wr(cfg_wr),
        .cfg_rd_core(cfg_rd_core),
        .cfg_rd_field(cfg_rd_field),
        .cfg_rd_data(cfg_rd_data),
        .periods(periods),
        .deadlines(deadlines),
        .priorities(priorities),
        .mode(mode),
        .period_reload(period_reload)
    );

    core_queue_bank #(
        .num_cores(num_cores),
        .queue_depth(queue_depth)
    ) core_queue_bank_i (
        .clock(clock),
        .rst(rst),
        .req_valid(req_valid),
        .req_packet(req_packet),
        .pop(pop),
        .pop_core(pop_core),
        .stall(stall),
        .nonempty(nonempty),
        .head(head)
    );

    deadline_timers #(
        .num_cores(num_cores)
    ) deadline_timers_i (
        .clock(clock),
        .rst(rst),
        .periods(periods),
        .deadlines(deadlines),
        .period_reload(period_reload),
        .remaining(remaining)
    );

    queue_selector #(
        .num_cores(num_cores)
    ) queue_selector_i (
        .clock(clock),
        .rst(rst),
        .nonempty(nonempty),
        .priorities(priorities),
        .remaining(remaining),
        .mode(mode),
        .grant_valid(grant_valid),
        .grant_core(grant_core)
    );

    packet_issuer #(
        .num_cores(num_cores)
    ) packet_issuer_i (
        .clock(clock),
        .rst(rst),
        .grant_valid(grant_valid),
        .grant_core(grant_core),
        .head(head),
        .out_consumed(out_consumed),
        .pop(pop),
        .pop_core(pop_core),
        .out_valid(out_valid),
        .out_packet(out_packet)
    );

endmodule

/* bench/memedf_tb.sv */
`timescale 1ns/100ps

module memedf_tb
    import memedf_pkg::*;
();

    localparam int num_cores   = 4;
    localparam int queue_depth = 4;
    localparam int cmp_w       = $bits(mem_packet_t);
    localparam int wait_limit  = 200;

    logic                clock = 1'b0;
    logic                rst;
    logic                req_valid;
    mem_packet_t         req_packet;
    logic                stall;
    cfg_write_t          cfg_wr;
    core_id_t            cfg_rd_core;
    cfg_field_t          cfg_rd_field;
    logic [timer_w-1:0]  cfg_rd_data;
    logic                out_valid;
    mem_packet_t         out_packet;
    logic                out_consumed = 1'b0;

    // Consumer state
    logic         releasing = 1'b0;
    int           idle_left = 0;
    logic         held_prev = 1'b0;
    mem_packet_t  held_packet;
    mem_packet_t  seen_q [$];

    memedf_top #(
        .num_cores(num_cores),
        .queue_depth(queue_depth)
    ) dut_i (
        .clock(clock),
        .rst(rst),
        .req_valid(req_valid),
        .req_packet(req_packet),
        .stall(stall),
        .cfg_wr(cfg_wr),
        .cfg_rd_core(cfg_rd_core),
        .cfg_rd_field(cfg_rd_field),
        .cfg_rd_data(cfg_rd_data),
        .out_valid(out_valid),
        .out_packet(out_packet),
        .out_consumed(out_consumed)
    );

    always #5 clock = ~clock;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string case_name, input logic [cmp_w-1:0] expected,
                               input logic [cmp_w-1:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", case_name, expected, actual);
            abort_run("value mismatch");
        end
    endtask

    ////////////////////
    // Case steps
    ////////////////////
    task automatic write_config(input logic [31:0] field, input logic [31:0] core,
                                input logic [31:0] value);
        @(negedge clock);
        cfg_wr.wr    = 1'b1;
        cfg_wr.field = cfg_field_t'(field[1:0]);
        cfg_wr.core  = core[2:0];
        cfg_wr.value = value[timer_w-1:0];
        @(negedge clock);
        cfg_wr.wr = 1'b0;
    endtask

    task automatic check_readback(input string case_name, input logic [31:0] field,
                                  input logic [31:0] core, input logic [31:0] expected);
        @(negedge clock);
        cfg_rd_field = cfg_field_t'(field[1:0]);
        cfg_rd_core  = core[2:0];
        #1;
        check_value(case_name, cmp_w'(expected[timer_w-1:0]), cmp_w'(cfg_rd_data));
    endtask

    // Holds the request until the addressed queue has room
    task automatic send_request(input logic [31:0] core, input logic [31:0] addr,
                                input logic [31:0] data);
        int waited;
        waited = 0;
        @(negedge clock);
        req_valid       = 1'b1;
        req_packet.core = core[2:0];
        req_packet.addr = addr;
        req_packet.data = data;
        #1;
        while (stall) begin
            if (waited == wait_limit) begin
                abort_run("request stalled for more than 200 cycles");
            end
            waited++;
            @(negedge clock);
            #1;
        end
        @(negedge clock);
        req_valid = 1'b0;
    endtask

    task automatic check_stall(input string case_name, input logic [31:0] core,
                               input logic [31:0] expected);
        @(negedge clock);
        req_valid       = 1'b0;
        req_packet.core = core[2:0];
        #1;
        check_value(case_name, cmp_w'(expected[0]), cmp_w'(stall));
    endtask

    task automatic expect_packet(input string case_name, input logic [31:0] core,
                                 input logic [31:0] addr, input logic [31:0] data);
        mem_packet_t expected;
        mem_packet_t actual;
        int waited;
        expected.core = core[2:0];
        expected.addr = addr;
        expected.data = data;
        waited = 0;
        while (seen_q.size() == 0) begin
            if (waited == wait_limit) begin
                abort_run("no packet was consumed within 200 cycles");
            end
            waited++;
            @(negedge clock);
            #1;
        end
        actual = seen_q.pop_front();
        check_value(case_name, expected, actual);
    endtask

    task automatic set_release(input logic on);
        @(negedge clock);
        #1;
        releasing = on;
    endtask

    ////////////////////
    // Output consumer
    ////////////////////
    always @(negedge clock) begin
        if (rst) begin
            out_consumed = 1'b0;
            held_prev    = 1'b0;
        end else begin
            // Output must stay put until it is consumed
            if (held_prev) begin
                check_value("held_valid", cmp_w'(1'b1), cmp_w'(out_valid));
                check_value("held_packet", held_packet, out_packet);
            end
            out_consumed = 1'b0;
            if (releasing && out_valid) begin
                if (idle_left == 0) begin
                    out_consumed = 1'b1;
                    seen_q.push_back(out_packet);
                    idle_left = int'($urandom % 4);
                end else begin
                    idle_left = idle_left - 1;
                end
            end
            held_prev   = out_valid && !out_consumed;
            held_packet = out_packet;
        end
    end

    initial begin
        int fd;
        int code;
        int nargs;
        string kind;
        string name;
        logic [31:0] arg_a;
        logic [31:0] arg_b;
        logic [31:0] arg_c;
        logic [8*160-1:0] skip_line;

        void'($urandom(76244));
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_packet   = '0;
        cfg_wr       = '0;
        cfg_rd_core  = '0;
        cfg_rd_field = field_period;
        arg_a        = '0;
        arg_b        = '0;
        arg_c        = '0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        fd = $fopen("bench/memedf_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open bench/memedf_cases.txt");
        end
        while (1) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                void'($fgets(skip_line, fd));
            end else begin
                if (kind == "hold" || kind == "rel") begin
                    nargs = 0;
                end else if (kind == "stl") begin
                    nargs = 2;
                end else begin
                    nargs = 3;
                end
                code = $fscanf(fd, "%s", name);
                if (nargs == 3) begin
                    code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
                end else if (nargs == 2) begin
                    code = $fscanf(fd, "%h %h", arg_a, arg_b);
                end else begin
                    code = 0;
                end
                if (code != nargs) begin
                    abort_run($sformatf("malformed case line for step %s", name));
                end
                if (kind == "cfgw") begin
                    write_config(arg_a, arg_b, arg_c);
                end else if (kind == "cfgr") begin
                    check_readback(name, arg_a, arg_b, arg_c);
                end else if (kind == "req") begin
                    send_request(arg_a, arg_b, arg_c);
                end else if (kind == "exp") begin
                    expect_packet(name, arg_a, arg_b, arg_c);
                end else if (kind == "stl") begin
                    check_stall(name, arg_a, arg_b);
                end else if (kind == "hold") begin
                    set_release(1'b0);
                end else if (kind == "rel") begin
                    set_release(1'b1);
                end else begin
                    abort_run($sformatf("unknown step kind %s in case file", kind));
                end
            end
        end
        $fclose(fd);

        if (seen_q.size() != 0) begin
            abort_run("more packets were issued than the cases expect");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* bench/memedf_cases.txt */
# kind name args in hex: cfgw and cfgr take field core value, req and exp take core addr data
# stl takes core and stall level, hold and rel take none; field 0 period 1 deadline 2 prio 3 mode
cfgr rst_period0 0 0 0
cfgr rst_deadline3 1 3 0
cfgr rst_priority2 2 2 0
cfgr rst_mode 3 0 0
cfgw set_prio0 2 0 3
cfgw set_prio1 2 1 1
cfgw set_prio2 2 2 1
cfgw set_prio3 2 3 0
cfgr get_prio0 2 0 3
cfgr get_prio2 2 2 1
rel ord_start
req ord_a 2 00001000 aaaa0001
req ord_b 2 00001004 aaaa0002
req ord_c 2 00001008 aaaa0003
exp ord_a 2 00001000 aaaa0001
exp ord_b 2 00001004 aaaa0002
exp ord_c 2 00001008 aaaa0003
hold fp_hold
req fp_a 0 00002000 b0000001
req fp_b 0 00002004 b0000002
req fp_c 2 00002008 b0000003
req fp_d 1 0000200c b0000004
req fp_e 3 00002010 b0000005
rel fp_release
exp fp_a 0 00002000 b0000001
exp fp_e 3 00002010 b0000005
exp fp_d 1 0000200c b0000004
exp fp_c 2 00002008 b0000003
exp fp_b 0 00002004 b0000002
cfgw set_dl0 1 0 0900
cfgw set_dl1 1 1 0300
cfgw set_dl2 1 2 0600
cfgw set_dl3 1 3 0c00
cfgw set_per0 0 0 ea60
cfgw set_per1 0 1 ea60
cfgw set_per2 0 2 ea60
cfgw set_per3 0 3 ea60
cfgw set_edf 3 0 1
cfgr get_dl3 1 3 0c00
cfgr get_per1 0 1 ea60
cfgr get_mode 3 0 1
hold edf_hold
req ed_a 3 00003000 c0000001
req ed_b 0 00003004 c0000002
req ed_c 3 00003008 c0000003
req ed_d 2 0000300c c0000004
req ed_e 1 00003010 c0000005
rel edf_release
exp ed_a 3 00003000 c0000001
exp ed_e 1 00003010 c0000005
exp ed_d 2 0000300c c0000004
exp ed_b 0 00003004 c0000002
exp ed_c 3 00003008 c0000003
hold bp_hold
req bp_a 1 00004000 d0000001
req bp_b 1 00004004 d0000002
req bp_c 1 00004008 d0000003
req bp_d 1 0000400c d0000004
req bp_e 1 00004010 d0000005
stl bp_full 1 1
stl bp_other 0 0
rel bp_release
req bp_f 1 00004014 d0000006
exp bp_a 1 00004000 d0000001
exp bp_b 1 00004004 d0000002
exp bp_c 1 00004008 d0000003
exp bp_d 1 0000400c d0000004
exp bp_e 1 00004010 d0000005
exp bp_f 1 00004014 d0000006

/* project.f */
rtl/memedf_pkg.sv
rtl/config_regs.sv
rtl/core_queue_bank.sv
rtl/deadline_timers.sv
rtl/queue_selector.sv
rtl/packet_issuer.sv
rtl/memedf_top.sv
bench/memedf_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memedf testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module memedf_tb -f project.f -o memedf_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/memedf_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
